// File: flist.f
+incdir+sim
hw/rv32i_pkg.sv
hw/alu_pkg.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/rv32i_core.sv
sim/tb_rv32i_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a nonzero exit means failure
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_rv32i_core -f flist.f \
    -o tb_rv32i_core &&
  ./obj_dir/tb_rv32i_core ||
  exit 1

// File: sim/tb_encode.svh
/*
  Instruction word builders for the RV32I formats, included in the testbench.
  Offsets are in bytes; bit 0 of branch and jump offsets is dropped.
*/
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// Register-register form, always the REGREG opcode
function automatic logic [31:0] r_format(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
  return {funct7, rs2, rs1, funct3, rd, rv32i_pkg::REGREG};
endfunction

// I form, shared by OP-IMM, loads and JALR
function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] funct3, input logic [4:0] rd,
                                         input logic [6:0] opcode);
  return {imm, rs1, funct3, rd, opcode};
endfunction

// SW only
function automatic logic [31:0] store_word(input logic [11:0] offset, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
  return {offset[11:5], rs2, rs1, 3'b010, offset[4:0], rv32i_pkg::STORE};
endfunction

function automatic logic [31:0] branch_word(input logic [12:0] offset, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [2:0] funct3);
  return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
          rv32i_pkg::BRANCH};
endfunction

// LUI or AUIPC
function automatic logic [31:0] upper_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opcode);
  return {imm, rd, opcode};
endfunction

function automatic logic [31:0] jal_word(input logic [20:0] offset, input logic [4:0] rd);
  return {offset[20], offset[10:1], offset[11], offset[19:12], rd, rv32i_pkg::JAL};
endfunction

`endif

// File: sim/tb_rv32i_core.sv
/*
  Directed tests for the single-cycle core. Both memories hold 256 words and
  answer in the same cycle. Programs start at the reset PC and end in EBREAK.
*/
`default_nettype none

module tb_rv32i_core;

  logic        clk = 1'b0;
  logic        arst_n = 1'b0;
  logic [31:0] imem_addr, imem_rdata, imem_off;
  logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_wen, dmem_ren, halt, illegal;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_val [$];
  logic [31:0] pre_addr [$];
  logic [31:0] pre_val [$];
  int          seed;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  `include "tb_encode.svh"

  rv32i_core dut0 (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .imem_addr_o  (imem_addr),
    .imem_rdata_i (imem_rdata),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_wen_o   (dmem_wen),
    .dmem_ren_o   (dmem_ren),
    .dmem_rdata_i (dmem_rdata),
    .halt_o       (halt),
    .illegal_o    (illegal)
  );

  always #10 clk = ~clk;

  assign imem_off   = imem_addr - rv32i_pkg::RESET_PC;
  assign imem_rdata = imem[imem_off[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (arst_n && dmem_wen) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // Counts only cycles out of reset
  always @(posedge clk) begin
    if (arst_n) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
        $display("Timeout: the core did not stop within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $fatal(1);
      end
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return ~addr ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] next_pc();
    return rv32i_pkg::RESET_PC + 32'(4 * prog.size());
  endfunction

  // Op index order ADD SUB SLL SRL SRA AND OR XOR SLT SLTU
  function automatic logic [31:0] isa_result(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
      0: return a + b;
      1: return a - b;
      2: return a << b[4:0];
      3: return a >> b[4:0];
      4: return $signed(a) >>> b[4:0];
      5: return a & b;
      6: return a | b;
      7: return a ^ b;
      8: return {31'b0, $signed(a) < $signed(b)};
      default: return {31'b0, a < b};
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic expect_word(input logic [31:0] addr, input logic [31:0] value);
    exp_addr.push_back(addr);
    exp_val.push_back(value);
  endtask

  task automatic preload(input logic [31:0] addr, input logic [31:0] value);
    pre_addr.push_back(addr);
    pre_val.push_back(value);
  endtask

  // Always two words, LUI then ADDI
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    emit(upper_word(hi[31:12], rd, rv32i_pkg::LUI));
    emit(i_format(value[11:0], rd, rv32i_pkg::ADDSUB, rd, rv32i_pkg::IMMED));
  endtask

  task automatic check_results(input string name);
    logic [31:0] a;
    logic [31:0] got;
    for (int k = 0; k < exp_addr.size(); k++) begin
      a = exp_addr[k];
      got = dmem[a[9:2]];
      assert (got == exp_val[k]) else begin
        $display("Error %s: mem[0x%h] expected 0x%h, actual 0x%h", name, a, exp_val[k], got);
        $display("Done: errors found");
        $fatal(1);
      end
    end
  endtask

  // Load enable is high exactly when the fetched word is a load
  task automatic check_load_enable(input string name);
    logic exp_ren;
    exp_ren = (imem_rdata[6:0] == rv32i_pkg::LOAD);
    assert (dmem_ren == exp_ren) else begin
      $display("Error %s: dmem_ren at PC 0x%h expected %b, actual %b",
               name, imem_addr, exp_ren, dmem_ren);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic run_program(input string name, input logic expect_illegal);
    logic [31:0] a;
    emit(rv32i_pkg::HALT_INSN);
    @(posedge clk);
    arst_n <= 1'b0;
    @(negedge clk);
    // Unused instruction words decode as illegal
    for (int i = 0; i < 256; i++) begin
      a = fill_word(rv32i_pkg::RESET_PC + 32'(4 * i));
      imem[i] = {a[31:7], 7'b1111111};
      dmem[i] <= fill_word(32'(4 * i));
    end
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    for (int i = 0; i < pre_addr.size(); i++) begin
      a = pre_addr[i];
      dmem[a[9:2]] <= pre_val[i];
    end
    cycle_limit = cycle_limit + 4 * prog.size();
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    while (!halt && !illegal) begin
      check_load_enable(name);
      @(negedge clk);
    end
    // A few more cycles to show that nothing commits once stopped
    repeat (3) @(negedge clk);
    assert (halt == !expect_illegal && illegal == expect_illegal) else begin
      $display("Error %s: halt/illegal expected %b/%b, actual %b/%b",
               name, !expect_illegal, expect_illegal, halt, illegal);
      $display("Done: errors found");
      $fatal(1);
    end
    check_results(name);
    prog.delete();
    exp_addr.delete();
    exp_val.delete();
    pre_addr.delete();
    pre_val.delete();
  endtask

  task automatic alu_test();
    logic [31:0] a, b, r, bval;
    logic [11:0] imm12;
    logic        is_shift;
    rv32i_pkg::alu_funct3_t f3 [10];
    logic [6:0]  f7 [10];
    f3 = '{rv32i_pkg::ADDSUB, rv32i_pkg::ADDSUB, rv32i_pkg::SLL, rv32i_pkg::SR,
           rv32i_pkg::SR, rv32i_pkg::AND, rv32i_pkg::OR, rv32i_pkg::XOR,
           rv32i_pkg::SLT, rv32i_pkg::SLTU};
    f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
    a = $random(seed);
    b = $random(seed);
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int op = 0; op < 10; op++) begin
      emit(r_format(f7[op], 5'd2, 5'd1, f3[op], 5'd3));
      emit(store_word(12'(12'h100 + 4 * op), 5'd3, 5'd0));
      expect_word(32'h100 + 32'(4 * op), isa_result(op, a, b));
      // No SUBI in the ISA
      if (op != 1) begin
        r = $random(seed);
        is_shift = (op >= 2 && op <= 4);
        imm12 = is_shift ? {f7[op], r[4:0]} : r[11:0];
        bval = is_shift ? {27'b0, r[4:0]} : {{20{imm12[11]}}, imm12};
        emit(i_format(imm12, 5'd1, f3[op], 5'd4, rv32i_pkg::IMMED));
        emit(store_word(12'(12'h180 + 4 * op), 5'd4, 5'd0));
        expect_word(32'h180 + 32'(4 * op), isa_result(op, a, bval));
      end
    end
    run_program("alu", 1'b0);
  endtask

  task automatic upper_test();
    logic [31:0] r1, r2, pc;
    r1 = $random(seed);
    r2 = $random(seed);
    emit(upper_word(r1[19:0], 5'd5, rv32i_pkg::LUI));
    pc = next_pc();
    emit(upper_word(r2[19:0], 5'd6, rv32i_pkg::AUIPC));
    emit(store_word(12'h100, 5'd5, 5'd0));
    emit(store_word(12'h104, 5'd6, 5'd0));
    expect_word(32'h100, {r1[19:0], 12'b0});
    expect_word(32'h104, pc + {r2[19:0], 12'b0});
    run_program("lui_auipc", 1'b0);
  endtask

  task automatic load_to_mem(input rv32i_pkg::load_t kind, input int off, input int slot,
                             input logic [31:0] value);
    emit(i_format(12'(12'h040 + off), 5'd0, kind, 5'd7, rv32i_pkg::LOAD));
    emit(store_word(12'(12'h100 + 4 * slot), 5'd7, 5'd0));
    expect_word(32'h100 + 32'(4 * slot), value);
  endtask

  task automatic load_test();
    logic [31:0] w, v;
    logic [7:0]  bt;
    logic [15:0] hw;
    int          slot;
    slot = 0;
    w = $random(seed);
    // Byte 3 negative and byte 0 positive, so both extensions show up
    w = {1'b1, w[30:8], 1'b0, w[6:0]};
    preload(32'h40, w);
    for (int off = 0; off < 4; off++) begin
      bt = w[8 * off +: 8];
      hw = w[16 * (off / 2) +: 16];
      load_to_mem(rv32i_pkg::LB, off, slot, {{24{bt[7]}}, bt});
      load_to_mem(rv32i_pkg::LBU, off, slot + 1, {24'b0, bt});
      slot = slot + 2;
      if (off % 2 == 0) begin
        load_to_mem(rv32i_pkg::LH, off, slot, {{16{hw[15]}}, hw});
        load_to_mem(rv32i_pkg::LHU, off, slot + 1, {16'b0, hw});
        slot = slot + 2;
      end
    end
    load_to_mem(rv32i_pkg::LW, 0, slot, w);
    v = $random(seed);
    load_const(5'd8, v);
    emit(store_word(12'h1f0, 5'd8, 5'd0));
    expect_word(32'h1f0, v);
    run_program("load_store", 1'b0);
  endtask

  task automatic branch_test();
    logic [31:0] a, b, va, vb, addr;
    logic [4:0]  rs_a, rs_b;
    logic        taken;
    rv32i_pkg::branch_t bt [6];
    bt = '{rv32i_pkg::BEQ, rv32i_pkg::BNE, rv32i_pkg::BLT, rv32i_pkg::BGE,
           rv32i_pkg::BLTU, rv32i_pkg::BGEU};
    a = $random(seed);
    b = $random(seed);
    // Signed and unsigned order disagree
    a[31] = 1'b1;
    b[31] = 1'b0;
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(i_format(12'h5a5, 5'd0, rv32i_pkg::ADDSUB, 5'd9, rv32i_pkg::IMMED));
    for (int t = 0; t < 6; t++) begin
      for (int p = 0; p < 3; p++) begin
        rs_a = (p == 1) ? 5'd2 : 5'd1;
        rs_b = (p == 0) ? 5'd2 : 5'd1;
        va = (rs_a == 5'd1) ? a : b;
        vb = (rs_b == 5'd1) ? a : b;
        case (bt[t])
          rv32i_pkg::BEQ:  taken = (va == vb);
          rv32i_pkg::BNE:  taken = (va != vb);
          rv32i_pkg::BLT:  taken = ($signed(va) < $signed(vb));
          rv32i_pkg::BGE:  taken = ($signed(va) >= $signed(vb));
          rv32i_pkg::BLTU: taken = (va < vb);
          default:         taken = (va >= vb);
        endcase
        addr = 32'h100 + 32'(4 * (3 * t + p));
        // Taken branch skips the marker store
        emit(branch_word(13'd8, rs_a, rs_b, bt[t]));
        emit(store_word(addr[11:0], 5'd9, 5'd0));
        expect_word(addr, taken ? fill_word(addr) : 32'h5a5);
      end
    end
    run_program("branch", 1'b0);
  endtask

  task automatic jump_test();
    logic [31:0] pc;
    emit(i_format(12'h5a5, 5'd0, rv32i_pkg::ADDSUB, 5'd9, rv32i_pkg::IMMED));
    pc = next_pc();
    emit(jal_word(21'd8, 5'd10));
    emit(store_word(12'h180, 5'd9, 5'd0));
    emit(store_word(12'h184, 5'd10, 5'd0));
    expect_word(32'h180, fill_word(32'h180));
    expect_word(32'h184, pc + 32'd4);
    // JALR sits after the two-word constant; rs1+2 is odd, bit 0 must clear
    pc = next_pc() + 32'd8;
    load_const(5'd11, pc + 32'd7);
    emit(i_format(12'd2, 5'd11, 3'b000, 5'd12, rv32i_pkg::JALR));
    emit(store_word(12'h188, 5'd9, 5'd0));
    // AUIPC at the target captures the PC the jump reached
    emit(upper_word(20'd0, 5'd13, rv32i_pkg::AUIPC));
    emit(store_word(12'h18c, 5'd12, 5'd0));
    emit(store_word(12'h190, 5'd13, 5'd0));
    expect_word(32'h188, fill_word(32'h188));
    expect_word(32'h18c, pc + 32'd4);
    expect_word(32'h190, pc + 32'd8);
    run_program("jal_jalr", 1'b0);
  endtask

  task automatic stop_test();
    emit(i_format(12'h5a5, 5'd0, rv32i_pkg::ADDSUB, 5'd9, rv32i_pkg::IMMED));
    emit(store_word(12'h104, 5'd9, 5'd0));
    emit(rv32i_pkg::HALT_INSN);
    emit(store_word(12'h100, 5'd9, 5'd0));
    expect_word(32'h104, 32'h5a5);
    expect_word(32'h100, fill_word(32'h100));
    run_program("ebreak", 1'b0);
    emit(i_format(12'h5a5, 5'd0, rv32i_pkg::ADDSUB, 5'd9, rv32i_pkg::IMMED));
    emit(store_word(12'h104, 5'd9, 5'd0));
    // custom-0 opcode, not in the decoded set
    emit(32'h0000_000b);
    emit(store_word(12'h100, 5'd9, 5'd0));
    expect_word(32'h104, 32'h5a5);
    expect_word(32'h100, fill_word(32'h100));
    run_program("illegal", 1'b1);
  endtask

  initial begin
    seed = 32'h91b47408;
    alu_test();
    upper_test();
    load_test();
    branch_test();
    jump_test();
    stop_test();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/rv32i_core.sv
/*
  Single-cycle RV32I core. Both memories must answer in the same cycle.
  EBREAK or an illegal word stops the core until reset; the PC then holds.
*/
`default_nettype none

module rv32i_core (
  input  logic        clk_i,
  input  logic        arst_n_i,
  output logic [31:0] imem_addr_o,
  input  logic [31:0] imem_rdata_i,
  output logic [31:0] dmem_addr_o,
  output logic [31:0] dmem_wdata_o,
  output logic        dmem_wen_o,
  output logic        dmem_ren_o,
  input  logic [31:0] dmem_rdata_i,
  output logic        halt_o,
  output logic        illegal_o
);

  logic [31:0] pc_q, pc_next, pc_plus4;
  logic        halt_q, illegal_q, commit;
  logic [4:0]  rs1, rs2, rd;
  logic [31:0] imm, rdata1, rdata2, alu_a, alu_b, alu_result;
  logic [31:0] load_data, wdata;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic        rf_wen, dwen, dren, is_branch, is_jump, is_jalr;
  logic        cu_halt, cu_illegal, taken;
  alu_pkg::alu_op_t     alu_op;
  alu_pkg::alu_a_sel_t  alu_a_sel;
  alu_pkg::alu_b_sel_t  alu_b_sel;
  alu_pkg::w_sel_t      w_sel;
  rv32i_pkg::load_t     load_type;
  rv32i_pkg::branch_t   branch_type;

  control_unit u_cu (
    .instr_i       (imem_rdata_i),
    .opcode_o      (),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd),
    .imm_o         (imm),
    .alu_op_o      (alu_op),
    .alu_a_sel_o   (alu_a_sel),
    .alu_b_sel_o   (alu_b_sel),
    .w_sel_o       (w_sel),
    .load_type_o   (load_type),
    .branch_type_o (branch_type),
    .wen_o         (rf_wen),
    .dwen_o        (dwen),
    .dren_o        (dren),
    .branch_o      (is_branch),
    .jump_o        (is_jump),
    .jalr_o        (is_jalr),
    .halt_o        (cu_halt),
    .illegal_o     (cu_illegal)
  );

  // Nothing commits once stopped, nor for the stopping word itself
  assign commit = ~(halt_q | illegal_q | cu_halt | cu_illegal);

  reg_file u_rf (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rd_i     (rd),
    .wen_i    (rf_wen & commit),
    .wdata_i  (wdata),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  assign alu_a = (alu_a_sel == alu_pkg::A_PC) ? pc_q : rdata1;
  assign alu_b = (alu_b_sel == alu_pkg::B_IMM) ? imm : rdata2;

  alu u_alu (
    .alu_op_i (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  always_comb begin
    case (branch_type)
      rv32i_pkg::BEQ:  taken = (rdata1 == rdata2);
      rv32i_pkg::BNE:  taken = (rdata1 != rdata2);
      rv32i_pkg::BLT:  taken = ($signed(rdata1) < $signed(rdata2));
      rv32i_pkg::BGE:  taken = ($signed(rdata1) >= $signed(rdata2));
      rv32i_pkg::BLTU: taken = (rdata1 < rdata2);
      rv32i_pkg::BGEU: taken = (rdata1 >= rdata2);
      default:         taken = 1'b0;
    endcase
  end

  // Byte lane from the low address bits of the aligned word
  assign ld_byte = dmem_rdata_i[{alu_result[1:0], 3'b000} +: 8];
  assign ld_half = alu_result[1] ? dmem_rdata_i[31:16] : dmem_rdata_i[15:0];

  always_comb begin
    case (load_type)
      rv32i_pkg::LB:  load_data = {{24{ld_byte[7]}}, ld_byte};
      rv32i_pkg::LBU: load_data = {24'b0, ld_byte};
      rv32i_pkg::LH:  load_data = {{16{ld_half[15]}}, ld_half};
      rv32i_pkg::LHU: load_data = {16'b0, ld_half};
      default:        load_data = dmem_rdata_i;
    endcase
  end

  assign pc_plus4 = pc_q + 32'd4;

  always_comb begin
    case (w_sel)
      alu_pkg::W_LOAD: wdata = load_data;
      alu_pkg::W_LINK: wdata = pc_plus4;
      alu_pkg::W_LUI:  wdata = imm;
      default:         wdata = alu_result;
    endcase
  end

  always_comb begin
    if (is_jalr)
      pc_next = (rdata1 + imm) & ~32'd1;
    else if (is_jump || (is_branch && taken))
      pc_next = pc_q + imm;
    else
      pc_next = pc_plus4;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q      <= rv32i_pkg::RESET_PC;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else if (commit) begin
      pc_q <= pc_next;
    end else if (!halt_q && !illegal_q) begin
      halt_q    <= cu_halt;
      illegal_q <= cu_illegal & ~cu_halt;
    end
  end

  assign imem_addr_o  = pc_q;
  assign dmem_addr_o  = alu_result;
  assign dmem_wdata_o = rdata2;
  assign dmem_wen_o   = dwen & commit;
  assign dmem_ren_o   = dren & commit;
  assign halt_o       = halt_q;
  assign illegal_o    = illegal_q;

endmodule

`default_nettype wire

// File: hw/alu.sv
/*
  32-bit integer ALU for the RV32I operations. Shifts use b_i[4:0].
*/
`default_nettype none

module alu (
  input  alu_pkg::alu_op_t alu_op_i,
  input  logic [31:0]      a_i,
  input  logic [31:0]      b_i,
  output logic [31:0]      result_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (alu_op_i)
      alu_pkg::ALU_ADD:  result_o = a_i + b_i;
      alu_pkg::ALU_SUB:  result_o = a_i - b_i;
      alu_pkg::ALU_SLL:  result_o = a_i << shamt;
      alu_pkg::ALU_SRL:  result_o = a_i >> shamt;
      alu_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      alu_pkg::ALU_AND:  result_o = a_i & b_i;
      alu_pkg::ALU_OR:   result_o = a_i | b_i;
      alu_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      // Compares give 0 or 1
      alu_pkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      alu_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
      default:           result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
/*
  32 x 32-bit register file. Reads are combinational, the write lands on
  the rising edge. x0 always reads zero.
*/
`default_nettype none

module reg_file (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  input  logic [4:0]  rd_i,
  input  logic        wen_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o
);

  logic [31:0] regs [32];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 is never written, so it stays at its reset value
  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

`default_nettype wire

// File: hw/control_unit.sv
/*
  Combinational RV32I decoder. Only SW is decoded as a store; other store
  widths write the full word. FENCE and non-EBREAK SYSTEM words are no-ops.
*/
`default_nettype none

module control_unit (
  input  logic [31:0]           instr_i,
  output rv32i_pkg::opcode_t    opcode_o,
  output logic [4:0]            rs1_o,
  output logic [4:0]            rs2_o,
  output logic [4:0]            rd_o,
  output logic [31:0]           imm_o,
  output alu_pkg::alu_op_t      alu_op_o,
  output alu_pkg::alu_a_sel_t   alu_a_sel_o,
  output alu_pkg::alu_b_sel_t   alu_b_sel_o,
  output alu_pkg::w_sel_t       w_sel_o,
  output rv32i_pkg::load_t      load_type_o,
  output rv32i_pkg::branch_t    branch_type_o,
  output logic                  wen_o,
  output logic                  dwen_o,
  output logic                  dren_o,
  output logic                  branch_o,
  output logic                  jump_o,
  output logic                  jalr_o,
  output logic                  halt_o,
  output logic                  illegal_o
);

  rv32i_pkg::alu_funct3_t funct3;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic        shamt_sel;
  logic        is_imm, is_reg, is_arith;

  assign opcode_o = rv32i_pkg::opcode_t'(instr_i[6:0]);
  assign funct3   = rv32i_pkg::alu_funct3_t'(instr_i[14:12]);

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  // Immediates per format, all sign-extended from bit 31
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  assign is_imm   = (opcode_o == rv32i_pkg::IMMED);
  assign is_reg   = (opcode_o == rv32i_pkg::REGREG);
  assign is_arith = is_imm | is_reg;

  // SRAI carries bit 30 in the I field, so pass only the shift amount
  assign shamt_sel = is_imm && (funct3 == rv32i_pkg::SLL || funct3 == rv32i_pkg::SR);

  always_comb begin
    case (opcode_o)
      rv32i_pkg::STORE:  imm_o = imm_s;
      rv32i_pkg::BRANCH: imm_o = imm_b;
      rv32i_pkg::LUI,
      rv32i_pkg::AUIPC:  imm_o = imm_u;
      rv32i_pkg::JAL:    imm_o = imm_j;
      default:           imm_o = shamt_sel ? {27'b0, instr_i[24:20]} : imm_i;
    endcase
  end

  assign load_type_o   = rv32i_pkg::load_t'(instr_i[14:12]);
  assign branch_type_o = rv32i_pkg::branch_t'(instr_i[14:12]);

  assign alu_a_sel_o = (opcode_o == rv32i_pkg::AUIPC) ? alu_pkg::A_PC : alu_pkg::A_RS1;
  assign alu_b_sel_o = (is_reg || opcode_o == rv32i_pkg::BRANCH) ? alu_pkg::B_RS2
                                                                  : alu_pkg::B_IMM;

  always_comb begin
    case (opcode_o)
      rv32i_pkg::LOAD:    w_sel_o = alu_pkg::W_LOAD;
      rv32i_pkg::JAL,
      rv32i_pkg::JALR:    w_sel_o = alu_pkg::W_LINK;
      rv32i_pkg::LUI:     w_sel_o = alu_pkg::W_LUI;
      default:            w_sel_o = alu_pkg::W_ALU;
    endcase
  end

  always_comb begin
    case (opcode_o)
      rv32i_pkg::IMMED, rv32i_pkg::REGREG,
      rv32i_pkg::LUI, rv32i_pkg::AUIPC,
      rv32i_pkg::JAL, rv32i_pkg::JALR,
      rv32i_pkg::LOAD:    wen_o = 1'b1;
      default:            wen_o = 1'b0;
    endcase
  end

  assign dwen_o   = (opcode_o == rv32i_pkg::STORE);
  assign dren_o   = (opcode_o == rv32i_pkg::LOAD);
  assign branch_o = (opcode_o == rv32i_pkg::BRANCH);
  assign jump_o   = (opcode_o == rv32i_pkg::JAL) || (opcode_o == rv32i_pkg::JALR);
  assign jalr_o   = (opcode_o == rv32i_pkg::JALR);

  // Loads, stores and AUIPC fall through to ADD
  always_comb begin
    if (!is_arith)
      alu_op_o = alu_pkg::ALU_ADD;
    else if (funct3 == rv32i_pkg::SLL)
      alu_op_o = alu_pkg::ALU_SLL;
    else if (funct3 == rv32i_pkg::SR && instr_i[30])
      alu_op_o = alu_pkg::ALU_SRA;
    else if (funct3 == rv32i_pkg::SR)
      alu_op_o = alu_pkg::ALU_SRL;
    else if (funct3 == rv32i_pkg::ADDSUB && is_reg && instr_i[30])
      alu_op_o = alu_pkg::ALU_SUB;
    else if (funct3 == rv32i_pkg::AND)
      alu_op_o = alu_pkg::ALU_AND;
    else if (funct3 == rv32i_pkg::OR)
      alu_op_o = alu_pkg::ALU_OR;
    else if (funct3 == rv32i_pkg::XOR)
      alu_op_o = alu_pkg::ALU_XOR;
    else if (funct3 == rv32i_pkg::SLT)
      alu_op_o = alu_pkg::ALU_SLT;
    else if (funct3 == rv32i_pkg::SLTU)
      alu_op_o = alu_pkg::ALU_SLTU;
    else
      alu_op_o = alu_pkg::ALU_ADD;
  end

  assign halt_o = (instr_i == rv32i_pkg::HALT_INSN);

  // funct7 bit 0 set means an M-extension word
  always_comb begin
    case (opcode_o)
      rv32i_pkg::REGREG:  illegal_o = instr_i[25];
      rv32i_pkg::LUI, rv32i_pkg::AUIPC,
      rv32i_pkg::JAL, rv32i_pkg::JALR,
      rv32i_pkg::BRANCH, rv32i_pkg::LOAD,
      rv32i_pkg::STORE, rv32i_pkg::IMMED,
      rv32i_pkg::MISCMEM, rv32i_pkg::SYSTEM: illegal_o = 1'b0;
      default:            illegal_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/alu_pkg.sv
/*
  ALU operations and the datapath mux selects driven by the decoder.
*/
`default_nettype none

package alu_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // First ALU operand
  typedef enum logic {
    A_RS1,
    A_PC
  } alu_a_sel_t;

  // Second ALU operand
  typedef enum logic {
    B_RS2,
    B_IMM
  } alu_b_sel_t;

  // Register write-back source
  typedef enum logic [1:0] {
    W_LOAD,
    W_LINK,
    W_LUI,
    W_ALU
  } w_sel_t;

endpackage

`default_nettype wire

// File: hw/rv32i_pkg.sv
/*
  RV32I base encodings shared by the decoder and the core.
  Only the opcodes and funct3 groups that the core handles are listed.
*/
`default_nettype none

package rv32i_pkg;

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  // Same funct3 codes for OP and OP-IMM
  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } alu_funct3_t;

  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // EBREAK stops the core
  localparam logic [31:0] HALT_INSN = 32'h0010_0073;
  localparam logic [31:0] RESET_PC  = 32'h0000_0000;

endpackage

`default_nettype wire
